//--- source/axi_mem_defs.svh
/* Widths and depths shared by the slice and the responder.
   RSP_FIFO_DEPTH must exceed N_REG_STAGES + N_READY_STAGES + 1, and N_REG_STAGES is at least 1 */
`ifndef AXI_MEM_DEFS_SVH
`define AXI_MEM_DEFS_SVH

// Bus widths
`define AXI_ADDR_W      12
`define AXI_DATA_W      32
`define AXI_STRB_W      (`AXI_DATA_W / 8)
`define AXI_ID_W        4

// Register slice depth, both request and response side
`define N_REG_STAGES    2
// Ready delay line length
`define N_READY_STAGES  `N_REG_STAGES

// Responder memory, word addressed
`define MEM_WORDS       256
// Entries per request FIFO in the responder
`define RSP_FIFO_DEPTH  16

`endif

//--- source/axi_mem_pkg.sv
/* Types shared by the slice, the responder and the testbench.
   Response codes follow the AXI BRESP/RRESP encoding */
package axi_mem_pkg;

    // ========================================================================
    // Response codes
    // ========================================================================

    // Two bits, same order as the bus encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        // Exclusive access, never produced by the responder
        RESP_EXOKAY = 2'b01,
        // Slave error, never produced by the responder
        RESP_SLVERR = 2'b10,
        // Address outside the memory range
        RESP_DECERR = 2'b11
    } axi_resp_e;

endpackage

//--- source/axi_req_stage.sv
/* Request register with no ready of its own.
   The sink must absorb every valid beat, which the almost-full ready scheme guarantees */
`timescale 1ns/1ps

module axi_req_stage #(
    // Payload width
    parameter int W = 8
) (
    input  logic         mem_sink,
    input  logic         rst,

    // Upstream side
    input  logic         valid_in,
    input  logic [W-1:0] data_in,

    // Downstream side
    output logic         valid_out,
    output logic [W-1:0] data_out
);

    // Valid is control state and clears in reset
    always_ff @(posedge mem_sink)
    begin
        if (rst)
        begin
            valid_out <= 1'b0;
        end
        else
        begin
            valid_out <= valid_in;
        end
    end

    // Payload follows every cycle, qualified only by valid_out
    always_ff @(posedge mem_sink)
    begin
        data_out <= data_in;
    end

endmodule

//--- source/axi_resp_stage.sv
/* One-entry ready/enable register for a response channel.
   Full throughput while the destination is ready, no combinational path from enable to enable */
`timescale 1ns/1ps

module axi_resp_stage #(
    // Payload width
    parameter int W = 8
) (
    input  logic         mem_sink,
    input  logic         rst,

    // Source side, toward the responder
    input  logic         enable_from_src,
    input  logic [W-1:0] data_from_src,
    output logic         ready_to_src,

    // Destination side, toward the bus source
    output logic         enable_to_dst,
    output logic [W-1:0] data_to_dst,
    input  logic         ready_from_dst
);

    logic         full;
    logic [W-1:0] data_q;

    // ========================================================================
    // Handshake
    // ========================================================================

    // Room when empty or when the held entry leaves this cycle
    assign ready_to_src  = !full || ready_from_dst;
    assign enable_to_dst = full;
    assign data_to_dst   = data_q;

    // Occupancy flag
    always_ff @(posedge mem_sink)
    begin
        if (rst)
        begin
            full <= 1'b0;
        end
        else if (ready_to_src)
        begin
            // Load or drain, depending on whether the source offers data
            full <= enable_from_src;
        end
    end

    // ========================================================================
    // Payload
    // ========================================================================

    // Held in place while the destination stalls
    always_ff @(posedge mem_sink)
    begin
        if (ready_to_src && enable_from_src)
        begin
            data_q <= data_from_src;
        end
    end

endmodule

//--- source/axi_mem_reg_simple.sv
/* Register slice; request readies are almost-full permissions, so a valid while ready is low is lost.
   The sink must hold N_REG_STAGES + N_READY_STAGES + 1 spare entries while it keeps ready high */
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module axi_mem_reg_simple (
    input  logic                   mem_sink,
    input  logic                   rst,

    // Source side requests
    input  logic                   awvalid, wvalid, arvalid,
    output logic                   awready, wready, arready,
    input  logic [`AXI_ADDR_W-1:0] awaddr, araddr,
    input  logic [`AXI_ID_W-1:0]   awid, arid,
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic [`AXI_STRB_W-1:0] wstrb,

    // Source side responses
    output logic                   bvalid, rvalid,
    input  logic                   bready, rready,
    output logic [`AXI_ID_W-1:0]   bid, rid,
    output axi_mem_pkg::axi_resp_e bresp, rresp,
    output logic [`AXI_DATA_W-1:0] rdata,

    // Sink side requests
    output logic                   snk_awvalid, snk_wvalid, snk_arvalid,
    input  logic                   snk_awready, snk_wready, snk_arready,
    output logic [`AXI_ADDR_W-1:0] snk_awaddr, snk_araddr,
    output logic [`AXI_ID_W-1:0]   snk_awid, snk_arid,
    output logic [`AXI_DATA_W-1:0] snk_wdata,
    output logic [`AXI_STRB_W-1:0] snk_wstrb,

    // Sink side responses
    input  logic                   snk_bvalid, snk_rvalid,
    output logic                   snk_bready, snk_rready,
    input  logic [`AXI_ID_W-1:0]   snk_bid, snk_rid,
    input  axi_mem_pkg::axi_resp_e snk_bresp, snk_rresp,
    input  logic [`AXI_DATA_W-1:0] snk_rdata
);

    localparam int NS  = `N_REG_STAGES;
    localparam int NR  = `N_READY_STAGES;
    // Payload widths per channel
    localparam int AXW = `AXI_ADDR_W + `AXI_ID_W;
    localparam int WW  = `AXI_DATA_W + `AXI_STRB_W;
    localparam int BW  = `AXI_ID_W + 2;
    localparam int RW  = `AXI_ID_W + `AXI_DATA_W + 2;

    // Index 0 is the sink end, index NS the source end
    logic           aw_v [0:NS];
    logic           w_v  [0:NS];
    logic           ar_v [0:NS];
    logic [AXW-1:0] aw_d [0:NS];
    logic [WW-1:0]  w_d  [0:NS];
    logic [AXW-1:0] ar_d [0:NS];
    logic           b_v  [0:NS];
    logic           b_r  [0:NS];
    logic [BW-1:0]  b_d  [0:NS];
    logic           r_v  [0:NS];
    logic           r_r  [0:NS];
    logic [RW-1:0]  r_d  [0:NS];

    // Ready delay line, bit order {ar, w, aw}
    logic [2:0]         snk_rdy;
    logic [NR-1:0][2:0] rdy_q;

    // ========================================================================
    // Source to sink, almost full
    // ========================================================================

    // Source edge, a beat enters only with permission
    assign aw_v[NS] = awvalid && awready;
    assign w_v[NS]  = wvalid && wready;
    assign ar_v[NS] = arvalid && arready;
    assign aw_d[NS] = {awaddr, awid};
    assign w_d[NS]  = {wdata, wstrb};
    assign ar_d[NS] = {araddr, arid};

    genvar s;
    for (s = 1; s <= NS; s++)
    begin : g_req
        axi_req_stage #(.W(AXW)) u_aw (
            .mem_sink, .rst, .valid_in(aw_v[s]), .data_in(aw_d[s]),
            .valid_out(aw_v[s-1]), .data_out(aw_d[s-1]));
        axi_req_stage #(.W(WW)) u_w (
            .mem_sink, .rst, .valid_in(w_v[s]), .data_in(w_d[s]),
            .valid_out(w_v[s-1]), .data_out(w_d[s-1]));
        axi_req_stage #(.W(AXW)) u_ar (
            .mem_sink, .rst, .valid_in(ar_v[s]), .data_in(ar_d[s]),
            .valid_out(ar_v[s-1]), .data_out(ar_d[s-1]));
    end

    // Sink edge
    assign snk_awvalid             = aw_v[0];
    assign {snk_awaddr, snk_awid}  = aw_d[0];
    assign snk_wvalid              = w_v[0];
    assign {snk_wdata, snk_wstrb}  = w_d[0];
    assign snk_arvalid             = ar_v[0];
    assign {snk_araddr, snk_arid}  = ar_d[0];

    // Sink readies enter at stage 0 and shift toward the source
    assign snk_rdy = {snk_arready, snk_wready, snk_awready};

    always_ff @(posedge mem_sink)
    begin
        if (rst)
        begin
            rdy_q <= '0;
        end
        else
        begin
            rdy_q[0] <= snk_rdy;
            for (int i = 1; i < NR; i++)
            begin
                rdy_q[i] <= rdy_q[i-1];
            end
        end
    end

    assign awready = rdy_q[NR-1][0];
    assign wready  = rdy_q[NR-1][1];
    assign arready = rdy_q[NR-1][2];

    // ========================================================================
    // Sink to source, normal ready/enable
    // ========================================================================

    // Responder end
    assign b_v[0]     = snk_bvalid;
    assign b_d[0]     = {snk_bid, snk_bresp};
    assign snk_bready = b_r[0];
    assign r_v[0]     = snk_rvalid;
    assign r_d[0]     = {snk_rid, snk_rdata, snk_rresp};
    assign snk_rready = r_r[0];

    for (s = 1; s <= NS; s++)
    begin : g_rsp
        axi_resp_stage #(.W(BW)) u_b (
            .mem_sink, .rst,
            .enable_from_src(b_v[s-1]), .data_from_src(b_d[s-1]), .ready_to_src(b_r[s-1]),
            .enable_to_dst(b_v[s]), .data_to_dst(b_d[s]), .ready_from_dst(b_r[s]));
        axi_resp_stage #(.W(RW)) u_r (
            .mem_sink, .rst,
            .enable_from_src(r_v[s-1]), .data_from_src(r_d[s-1]), .ready_to_src(r_r[s-1]),
            .enable_to_dst(r_v[s]), .data_to_dst(r_d[s]), .ready_from_dst(r_r[s]));
    end

    // Source end
    assign bvalid  = b_v[NS];
    assign bid     = b_d[NS][BW-1:2];
    assign bresp   = axi_mem_pkg::axi_resp_e'(b_d[NS][1:0]);
    assign b_r[NS] = bready;
    assign rvalid  = r_v[NS];
    assign rid     = r_d[NS][RW-1:`AXI_DATA_W+2];
    assign rdata   = r_d[NS][`AXI_DATA_W+1:2];
    assign rresp   = axi_mem_pkg::axi_resp_e'(r_d[NS][1:0]);
    assign r_r[NS] = rready;

endmodule

//--- source/axi_mem_responder.sv
/* Word-addressed memory sink, single-beat only, responses in arrival order per channel.
   Low address bits are ignored; out-of-range accesses get DECERR and read data of zero */
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module axi_mem_responder (
    input  logic                   mem_sink,
    input  logic                   rst,

    // Requests from the slice
    input  logic                   snk_awvalid, snk_wvalid, snk_arvalid,
    output logic                   snk_awready, snk_wready, snk_arready,
    input  logic [`AXI_ADDR_W-1:0] snk_awaddr, snk_araddr,
    input  logic [`AXI_ID_W-1:0]   snk_awid, snk_arid,
    input  logic [`AXI_DATA_W-1:0] snk_wdata,
    input  logic [`AXI_STRB_W-1:0] snk_wstrb,

    // Responses to the slice
    output logic                   snk_bvalid, snk_rvalid,
    input  logic                   snk_bready, snk_rready,
    output logic [`AXI_ID_W-1:0]   snk_bid, snk_rid,
    output axi_mem_pkg::axi_resp_e snk_bresp, snk_rresp,
    output logic [`AXI_DATA_W-1:0] snk_rdata
);

    localparam int DEPTH  = `RSP_FIFO_DEPTH;
    localparam int PW     = $clog2(DEPTH);
    // Widest payload is W, AW and AR are zero extended into it
    localparam int CW     = `AXI_DATA_W + `AXI_STRB_W;
    localparam int AXW    = `AXI_ADDR_W + `AXI_ID_W;
    localparam int MW     = $clog2(`MEM_WORDS);
    // Spare entries that must stay free while ready is high
    localparam int THRESH = `N_REG_STAGES + `N_READY_STAGES + 1;

    // Channel 0 is AW, 1 is W, 2 is AR
    logic          fifo_push  [3];
    logic          fifo_pop   [3];
    logic [CW-1:0] fifo_din   [3];
    logic [CW-1:0] fifo_dout  [3];
    logic          fifo_nempty[3];
    logic          fifo_rdy   [3];

    logic [`AXI_DATA_W-1:0] mem [`MEM_WORDS];

    logic [`AXI_ADDR_W-1:0] wa_addr, ra_addr;
    logic [`AXI_ID_W-1:0]   wa_id, ra_id;
    logic [`AXI_DATA_W-1:0] w_data;
    logic [`AXI_STRB_W-1:0] w_strb;
    logic                   wa_ok, ra_ok, do_write, do_read;

    assign fifo_push[0] = snk_awvalid;
    assign fifo_push[1] = snk_wvalid;
    assign fifo_push[2] = snk_arvalid;
    assign fifo_din[0]  = CW'({snk_awaddr, snk_awid});
    assign fifo_din[1]  = {snk_wdata, snk_wstrb};
    assign fifo_din[2]  = CW'({snk_araddr, snk_arid});

    // ========================================================================
    // Request FIFOs
    // ========================================================================

    genvar c;
    for (c = 0; c < 3; c++)
    begin : g_fifo
        logic [CW-1:0] ram [DEPTH];
        logic [PW-1:0] wr_ptr, rd_ptr;
        logic [PW:0]   count;
        logic          rdy_q;

        always_ff @(posedge mem_sink)
        begin
            if (rst)
            begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
                rdy_q  <= 1'b0;
            end
            else
            begin
                wr_ptr <= wr_ptr + PW'(fifo_push[c]);
                rd_ptr <= rd_ptr + PW'(fifo_pop[c]);
                count  <= count + (PW+1)'(fifo_push[c]) - (PW+1)'(fifo_pop[c]);
                // Registered almost-full, the extra cycle is part of THRESH
                rdy_q  <= (DEPTH - int'(count)) > THRESH;
            end
        end

        always_ff @(posedge mem_sink)
        begin
            if (fifo_push[c])
            begin
                ram[wr_ptr] <= fifo_din[c];
            end
        end

        assign fifo_dout[c]   = ram[rd_ptr];
        assign fifo_nempty[c] = count != '0;
        assign fifo_rdy[c]    = rdy_q;
    end

    assign snk_awready = fifo_rdy[0];
    assign snk_wready  = fifo_rdy[1];
    assign snk_arready = fifo_rdy[2];

    // ========================================================================
    // Retire and decode
    // ========================================================================

    assign {wa_addr, wa_id}  = fifo_dout[0][AXW-1:0];
    assign {w_data, w_strb}  = fifo_dout[1];
    assign {ra_addr, ra_id}  = fifo_dout[2][AXW-1:0];
    assign wa_ok = wa_addr[`AXI_ADDR_W-1:2] < `MEM_WORDS;
    assign ra_ok = ra_addr[`AXI_ADDR_W-1:2] < `MEM_WORDS;

    // Write needs both heads and a free or draining B register
    assign do_write    = fifo_nempty[0] && fifo_nempty[1] && (!snk_bvalid || snk_bready);
    assign do_read     = fifo_nempty[2] && (!snk_rvalid || snk_rready);
    assign fifo_pop[0] = do_write;
    assign fifo_pop[1] = do_write;
    assign fifo_pop[2] = do_read;

    // Byte-merged write, nothing stored when out of range
    always_ff @(posedge mem_sink)
    begin
        if (do_write && wa_ok)
        begin
            for (int i = 0; i < `AXI_STRB_W; i++)
            begin
                if (w_strb[i])
                begin
                    mem[wa_addr[MW+1:2]][8*i +: 8] <= w_data[8*i +: 8];
                end
            end
        end
    end

    // ========================================================================
    // Response registers
    // ========================================================================

    always_ff @(posedge mem_sink)
    begin
        if (rst)
        begin
            snk_bvalid <= 1'b0;
            snk_rvalid <= 1'b0;
        end
        else
        begin
            snk_bvalid <= do_write || (snk_bvalid && !snk_bready);
            snk_rvalid <= do_read || (snk_rvalid && !snk_rready);
        end
    end

    // Payloads load only on retire
    always_ff @(posedge mem_sink)
    begin
        if (do_write)
        begin
            snk_bid   <= wa_id;
            snk_bresp <= wa_ok ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_DECERR;
        end
        if (do_read)
        begin
            snk_rid   <= ra_id;
            snk_rresp <= ra_ok ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_DECERR;
            snk_rdata <= ra_ok ? mem[ra_addr[MW+1:2]] : '0;
        end
    end

endmodule

//--- source/axi_mem_shim_top.sv
/* Register slice in front of the memory responder.
   The source may raise a request valid only while the matching ready is high */
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module axi_mem_shim_top (
    input  logic                   mem_sink,
    input  logic                   rst,

    // Requests
    input  logic                   awvalid, wvalid, arvalid,
    output logic                   awready, wready, arready,
    input  logic [`AXI_ADDR_W-1:0] awaddr, araddr,
    input  logic [`AXI_ID_W-1:0]   awid, arid,
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic [`AXI_STRB_W-1:0] wstrb,

    // Responses
    output logic                   bvalid, rvalid,
    input  logic                   bready, rready,
    output logic [`AXI_ID_W-1:0]   bid, rid,
    output axi_mem_pkg::axi_resp_e bresp, rresp,
    output logic [`AXI_DATA_W-1:0] rdata
);

    // Sink side of the slice
    logic                   snk_awvalid, snk_wvalid, snk_arvalid;
    logic                   snk_awready, snk_wready, snk_arready;
    logic [`AXI_ADDR_W-1:0] snk_awaddr, snk_araddr;
    logic [`AXI_ID_W-1:0]   snk_awid, snk_arid, snk_bid, snk_rid;
    logic [`AXI_DATA_W-1:0] snk_wdata, snk_rdata;
    logic [`AXI_STRB_W-1:0] snk_wstrb;
    logic                   snk_bvalid, snk_rvalid, snk_bready, snk_rready;
    axi_mem_pkg::axi_resp_e snk_bresp, snk_rresp;

    axi_mem_reg_simple u_axi_mem_reg_simple (.*);

    axi_mem_responder u_axi_mem_responder (.*);

endmodule

//--- verification/tb_axi_mem_shim.sv
/* Reads and writes may pass each other in the responder, so the driver drains one kind first.
   Golden writes are replayed afterwards and must leave memory as the first pass left it */
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module tb_axi_mem_shim;

    localparam string GOLDEN_FILE    = "verification/axi_mem_golden.txt";
    localparam int    MAX_OPS        = 32;
    // kind, id, addr, data, strb, resp, rdata
    localparam int    FIELDS         = 7;
    // Extra back-to-back passes over the writes of the file
    localparam int    REPLAYS        = 2;
    localparam int    TIMEOUT_PER_OP = 4 * `N_REG_STAGES + 20;
    localparam int    TIMEOUT_MARGIN = 100;

    logic                   mem_sink, rst;
    logic                   awvalid, wvalid, arvalid, awready, wready, arready;
    logic [`AXI_ADDR_W-1:0] awaddr, araddr;
    logic [`AXI_ID_W-1:0]   awid, arid, bid, rid;
    logic [`AXI_DATA_W-1:0] wdata, rdata;
    logic [`AXI_STRB_W-1:0] wstrb;
    logic                   bvalid, rvalid, bready, rready;
    axi_mem_pkg::axi_resp_e bresp, rresp;

    logic [31:0] golden [MAX_OPS*FIELDS];
    int          n_ops = 0;
    // Expected responses in issue order as {id, resp} for B and {id, resp, data} for R
    logic [`AXI_ID_W+1:0]             b_exp [$];
    logic [`AXI_ID_W+`AXI_DATA_W+1:0] r_exp [$];

    axi_mem_shim_top u_axi_mem_shim_top (.*);

    // ========================================================================
    // Checks
    // ========================================================================

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED: %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1)
        else
        begin
            $display("%s", what);
            $display("Simulation failed");
            $fatal(1, "Run stopped");
        end
    endtask

    // Nothing may move while reset holds or just after it
    task automatic check_idle();
        check_value("awready", 32'h0, 32'(awready));
        check_value("wready", 32'h0, 32'(wready));
        check_value("arready", 32'h0, 32'(arready));
        check_value("bvalid", 32'h0, 32'(bvalid));
        check_value("rvalid", 32'h0, 32'(rvalid));
    endtask

    task automatic check_b_beat();
        logic [`AXI_ID_W+1:0] exp;
        check_true(b_exp.size() != 0, "A write response arrived with no write outstanding");
        exp = b_exp.pop_front();
        check_value("bid", 32'(exp[`AXI_ID_W+1:2]), 32'(bid));
        check_value("bresp", 32'(exp[1:0]), 32'(bresp));
    endtask

    task automatic check_r_beat();
        logic [`AXI_ID_W+`AXI_DATA_W+1:0] exp;
        check_true(r_exp.size() != 0, "A read response arrived with no read outstanding");
        exp = r_exp.pop_front();
        check_value("rid", 32'(exp[`AXI_ID_W+`AXI_DATA_W+1:`AXI_DATA_W+2]), 32'(rid));
        check_value("rresp", 32'(exp[`AXI_DATA_W+1:`AXI_DATA_W]), 32'(rresp));
        check_value("rdata", 32'(exp[`AXI_DATA_W-1:0]), 32'(rdata));
    endtask

    // Handshakes complete on the rising edge with values from before the update
    always @(posedge mem_sink)
    begin
        if (!rst && bvalid && bready)
        begin
            check_b_beat();
        end
        if (!rst && rvalid && rready)
        begin
            check_r_beat();
        end
    end

    // ========================================================================
    // Drivers that start and return on a falling edge
    // ========================================================================

    // AW and W go out together and only while both readies permit
    task automatic drive_write(input int base);
        while (!(awready && wready))
        begin
            @(negedge mem_sink);
        end
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awid    = golden[base+1][`AXI_ID_W-1:0];
        awaddr  = golden[base+2][`AXI_ADDR_W-1:0];
        wdata   = golden[base+3][`AXI_DATA_W-1:0];
        wstrb   = golden[base+4][`AXI_STRB_W-1:0];
        b_exp.push_back({awid, golden[base+5][1:0]});
        @(negedge mem_sink);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic drive_read(input int base);
        while (!arready)
        begin
            @(negedge mem_sink);
        end
        arvalid = 1'b1;
        arid    = golden[base+1][`AXI_ID_W-1:0];
        araddr  = golden[base+2][`AXI_ADDR_W-1:0];
        r_exp.push_back({arid, golden[base+5][1:0], golden[base+6][`AXI_DATA_W-1:0]});
        @(negedge mem_sink);
        arvalid = 1'b0;
    endtask

    // ========================================================================
    // Clock, back-pressure, watchdog
    // ========================================================================

    initial
    begin
        mem_sink = 1'b0;
        forever #5 mem_sink = ~mem_sink;
    end

    // Response readies high about one cycle in four once reset is over
    initial
    begin
        void'($urandom(32'hcbf5));
        wait (rst === 1'b0);
        forever
        begin
            @(negedge mem_sink);
            bready = ($urandom % 4) == 0;
            rready = ($urandom % 4) == 0;
        end
    end

    initial
    begin
        wait (n_ops > 0);
        repeat (n_ops * (REPLAYS + 1) * TIMEOUT_PER_OP + TIMEOUT_MARGIN) @(posedge mem_sink);
        $display("Timeout: not all responses arrived within the allowed cycles");
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial
    begin
        int count;
        rst     = 1'b1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        awaddr  = '0;
        awid    = '0;
        wdata   = '0;
        wstrb   = '0;
        araddr  = '0;
        arid    = '0;
        bready  = 1'b0;
        rready  = 1'b0;

        // Fill marks the end of the operations, every entry above any kind
        for (int i = 0; i < MAX_OPS * FIELDS; i++)
        begin
            golden[i] = ~32'(i);
        end
        $readmemh(GOLDEN_FILE, golden);
        count = 0;
        while (count < MAX_OPS && golden[count*FIELDS] <= 32'h1)
        begin
            count++;
        end
        check_true(count > 0, "The golden file holds no operations");
        n_ops = count;

        repeat (4)
        begin
            @(negedge mem_sink);
            check_idle();
        end
        rst = 1'b0;
        @(negedge mem_sink);
        check_idle();

        // Ready must come up with no request sent
        while (!(awready && wready && arready))
        begin
            @(negedge mem_sink);
        end

        // Later passes replay only the writes so that the responder FIFOs fill up
        for (int p = 0; p <= REPLAYS; p++)
        begin
            for (int k = 0; k < n_ops; k++)
            begin
                if (golden[k*FIELDS] == 32'h0)
                begin
                    while (r_exp.size() != 0)
                    begin
                        @(negedge mem_sink);
                    end
                    drive_write(k * FIELDS);
                end
                else if (p == 0)
                begin
                    while (b_exp.size() != 0)
                    begin
                        @(negedge mem_sink);
                    end
                    drive_read(k * FIELDS);
                end
            end
        end

        while (b_exp.size() != 0 || r_exp.size() != 0)
        begin
            @(negedge mem_sink);
        end
        // Quiet tail in which a repeated response would hit an empty queue
        repeat (4 * `N_REG_STAGES + 10) @(negedge mem_sink);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verification/axi_mem_golden.txt
// kind(0 write, 1 read) id addr data strb exp_resp(0 OKAY, 3 DECERR) exp_rdata
// Reads ignore data and strb, writes ignore exp_rdata
0 1 000 11223344 f 0 00000000
1 2 000 00000000 0 0 11223344
0 3 020 a5a5a5a5 f 0 00000000
0 4 020 00ff0000 4 0 00000000
1 5 020 00000000 0 0 a5ffa5a5
0 6 400 deadbeef f 3 00000000
0 8 ffc 12345678 f 3 00000000
1 7 400 00000000 0 3 00000000
1 9 ffc 00000000 0 3 00000000
1 1 000 00000000 0 0 11223344
1 3 020 00000000 0 0 a5ffa5a5
0 a 100 c0de0100 f 0 00000000
0 b 104 c0de0104 f 0 00000000
0 c 108 c0de0108 f 0 00000000
0 d 10c c0de010c f 0 00000000
0 e 104 ffff9999 3 0 00000000
0 f 110 c0de0110 f 0 00000000
1 0 100 00000000 0 0 c0de0100
1 6 104 00000000 0 0 c0de9999
1 c 108 00000000 0 0 c0de0108
1 4 10c 00000000 0 0 c0de010c
1 8 110 00000000 0 0 c0de0110

//--- axi_mem_shim_top.f
+incdir+source
source/axi_mem_pkg.sv
source/axi_req_stage.sv
source/axi_resp_stage.sv
source/axi_mem_reg_simple.sv
source/axi_mem_responder.sv
source/axi_mem_shim_top.sv
verification/tb_axi_mem_shim.sv

//--- Bender.yml
package:
  name: axi_mem_shim

sources:
  - include_dirs:
      - source
    files:
      - source/axi_mem_pkg.sv
      - source/axi_req_stage.sv
      - source/axi_resp_stage.sv
      - source/axi_mem_reg_simple.sv
      - source/axi_mem_responder.sv
      - source/axi_mem_shim_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_axi_mem_shim.sv
